//--- files.f
source/cpu_pkg.sv
source/alu.sv
source/fetch_stage.sv
source/decode_stage.sv
source/forwarding_unit.sv
source/execute_stage.sv
source/memory_writeback_stage.sv
source/processor.sv
verification/clock_gen.sv
verification/processor_tb.sv

//--- source/alu.sv
/*
 * 32-bit ALU
 * add, sub, and, or, sll and sra, all combinational and wrapping
 */
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  word_t      operand_a,
    input  word_t      operand_b,
    input  alu_op_t    alu_op,
    input  logic [4:0] shamt,
    output word_t      result
);

    always_comb begin
        case (alu_op)
            ALU_ADD: result = operand_a + operand_b;  // Overflow wraps
            ALU_SUB: result = operand_a - operand_b;
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            ALU_SLL: result = operand_a << shamt;
            ALU_SRA: result = word_t'($signed(operand_a) >>> shamt);  // Sign fills from top
            default: result = '0;  // Unknown op never writes anyway
        endcase
    end

endmodule

`default_nettype wire

//--- source/cpu_pkg.sv
/*
 * Core-wide definitions for the five-stage pipeline
 * Word and register types, opcode and ALU codes, operand sources, field positions
 */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;      // Data or address word
    typedef logic [4:0]  reg_addr_t;  // Register number

    // Major opcodes, bits 31:27
    typedef enum logic [4:0] {
        OP_RTYPE = 5'b00000,
        OP_J     = 5'b00001,
        OP_ADDI  = 5'b00101,
        OP_SW    = 5'b00111,
        OP_LW    = 5'b01000
    } opcode_t;

    // R-type function codes, bits 6:2
    typedef enum logic [4:0] {
        ALU_ADD = 5'b00000,
        ALU_SUB = 5'b00001,
        ALU_AND = 5'b00010,
        ALU_OR  = 5'b00011,
        ALU_SLL = 5'b00100,
        ALU_SRA = 5'b00101
    } alu_op_t;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,  // Value latched from the register file
        FWD_XM   = 2'b01,  // ALU result sitting in memory stage
        FWD_LOAD = 2'b10,  // Load data coming back on q_dmem
        FWD_MW   = 2'b11   // Writeback data
    } fwd_sel_t;

    // Instruction field positions
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 27;
    localparam int RD_MSB     = 26;
    localparam int RD_LSB     = 22;
    localparam int RS_MSB     = 21;
    localparam int RS_LSB     = 17;
    localparam int RT_MSB     = 16;
    localparam int RT_LSB     = 12;
    localparam int SHAMT_MSB  = 11;
    localparam int SHAMT_LSB  = 7;
    localparam int ALUOP_MSB  = 6;
    localparam int ALUOP_LSB  = 2;
    localparam int IMM_MSB    = 16;  // 17-bit immediate, sign-extended
    localparam int TARGET_MSB = 26;  // 27-bit jump target, zero-extended

    // add $0, $0, $0 ... never writes
    localparam word_t NOP_WORD = 32'd0;

endpackage

`default_nettype wire

//--- source/decode_stage.sv
/*
 * Decode stage
 * Splits the instruction, decodes control, drives the register file read ports,
 * resolves j and loads the DX latch
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  word_t       fd_instr,
    input  word_t       data_read_reg_a,
    input  word_t       data_read_reg_b,
    output reg_addr_t   ctrl_read_reg_a,
    output reg_addr_t   ctrl_read_reg_b,
    output logic        jump_taken,
    output word_t       jump_target,
    output word_t       dx_a,
    output word_t       dx_b,
    output word_t       dx_imm,
    output reg_addr_t   dx_rs,
    output reg_addr_t   dx_rt,
    output reg_addr_t   dx_rd,
    output logic [4:0]  dx_shamt,
    output alu_op_t     dx_alu_op,
    output logic        dx_use_imm,
    output logic        dx_reg_write,
    output logic        dx_mem_read,
    output logic        dx_mem_write
);

    opcode_t    opcode;
    reg_addr_t  rd;
    reg_addr_t  rs;
    reg_addr_t  rt;
    logic [4:0] shamt;
    logic [4:0] aluop_field;
    word_t      imm_ext;

    // Decoded control levels
    alu_op_t    alu_op;
    logic       use_imm;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       read_b_rd;  // sw reads its data register through port B

    // Field extraction
    assign opcode      = opcode_t'(fd_instr[OPCODE_MSB:OPCODE_LSB]);
    assign rd          = fd_instr[RD_MSB:RD_LSB];
    assign rs          = fd_instr[RS_MSB:RS_LSB];
    assign rt          = fd_instr[RT_MSB:RT_LSB];
    assign shamt       = fd_instr[SHAMT_MSB:SHAMT_LSB];
    assign aluop_field = fd_instr[ALUOP_MSB:ALUOP_LSB];
    assign imm_ext     = {{15{fd_instr[IMM_MSB]}}, fd_instr[IMM_MSB:0]};

    // ----------------------------------------------------------
    // Control decode
    // ----------------------------------------------------------
    always_comb begin
        alu_op     = ALU_ADD;  // lw, sw and addi all add
        use_imm    = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        read_b_rd  = 1'b0;
        jump_taken = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                alu_op = alu_op_t'(aluop_field);
                case (alu_op_t'(aluop_field))
                    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRA: reg_write = 1'b1;
                    default: reg_write = 1'b0;  // Unknown function, no write
                endcase
            end
            OP_ADDI: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            OP_SW: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
                read_b_rd = 1'b1;
            end
            OP_J:    jump_taken = 1'b1;  // All other levels stay low, j moves on as a nop
            default: ;                   // Unknown opcode behaves as a nop
        endcase
    end

    assign jump_target     = {5'd0, fd_instr[TARGET_MSB:0]};  // Absolute word address
    assign ctrl_read_reg_a = rs;
    assign ctrl_read_reg_b = read_b_rd ? rd : rt;

    // ----------------------------------------------------------
    // DX latch
    // ----------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            dx_reg_write <= 1'b0;
            dx_mem_read  <= 1'b0;
            dx_mem_write <= 1'b0;
        end else begin
            dx_reg_write <= reg_write && (rd != 5'd0);  // $0 is never a destination
            dx_mem_read  <= mem_read;
            dx_mem_write <= mem_write;
        end
    end

    // Operands and fields
    always_ff @(posedge clock) begin
        dx_a       <= data_read_reg_a;
        dx_b       <= data_read_reg_b;
        dx_imm     <= imm_ext;
        dx_rs      <= rs;
        dx_rt      <= ctrl_read_reg_b;  // Whichever register port B read
        dx_rd      <= rd;
        dx_shamt   <= shamt;
        dx_alu_op  <= alu_op;
        dx_use_imm <= use_imm;
    end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
/*
 * Execute stage
 * Forwarded operand muxes, immediate select, ALU and the XM latch
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  word_t       dx_a,
    input  word_t       dx_b,
    input  word_t       dx_imm,
    input  reg_addr_t   dx_rd,
    input  logic [4:0]  dx_shamt,
    input  alu_op_t     dx_alu_op,
    input  logic        dx_use_imm,
    input  logic        dx_reg_write,
    input  logic        dx_mem_read,
    input  logic        dx_mem_write,
    input  fwd_sel_t    fwd_a,
    input  fwd_sel_t    fwd_b,
    input  word_t       q_dmem,          // Load data, same cycle
    input  word_t       data_write_reg,  // Writeback data
    output word_t       xm_result,
    output word_t       xm_store_data,
    output reg_addr_t   xm_rd,
    output logic        xm_reg_write,
    output logic        xm_mem_read,
    output logic        xm_mem_write
);

    word_t operand_a;
    word_t fwd_b_value;  // Also the store data
    word_t operand_b;
    word_t alu_result;

    // Both operand muxes share this selection
    function automatic word_t select_operand(
        input fwd_sel_t sel,
        input word_t    latched,
        input word_t    xm_value,
        input word_t    load_value,
        input word_t    mw_value
    );
        word_t value;
        case (sel)
            FWD_XM:   value = xm_value;
            FWD_LOAD: value = load_value;
            FWD_MW:   value = mw_value;
            default:  value = latched;
        endcase
        return value;
    endfunction

    // ----------------------------------------------------------
    // Operand selection
    // ----------------------------------------------------------
    always_comb begin
        operand_a   = select_operand(fwd_a, dx_a, xm_result, q_dmem, data_write_reg);
        fwd_b_value = select_operand(fwd_b, dx_b, xm_result, q_dmem, data_write_reg);
    end

    assign operand_b = dx_use_imm ? dx_imm : fwd_b_value;  // Immediate replaces B

    alu alu_i (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .alu_op    (dx_alu_op),
        .shamt     (dx_shamt),
        .result    (alu_result)
    );

    // ----------------------------------------------------------
    // XM latch
    // ----------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            xm_reg_write <= 1'b0;
            xm_mem_read  <= 1'b0;
            xm_mem_write <= 1'b0;
        end else begin
            xm_reg_write <= dx_reg_write;
            xm_mem_read  <= dx_mem_read;
            xm_mem_write <= dx_mem_write;
        end
    end

    always_ff @(posedge clock) begin
        xm_result     <= alu_result;   // Address for lw and sw
        xm_store_data <= fwd_b_value;
        xm_rd         <= dx_rd;
    end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
/*
 * Fetch stage
 * Program counter, next-PC choice and the FD latch, squashed on a jump
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  jump_taken,    // Redirect strobe from decode
    input  word_t jump_target,
    input  word_t q_imem,
    output word_t address_imem,
    output word_t fd_instr,
    output word_t fd_pc
);

    word_t pc;
    word_t pc_plus_one;
    word_t next_pc;

    assign pc_plus_one  = pc + 32'd1;
    assign next_pc      = jump_taken ? jump_target : pc_plus_one;  // Jump wins over sequential
    assign address_imem = pc;

    // ----------------------------------------------------------
    // PC and FD latch
    // ----------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            pc       <= '0;
            fd_instr <= NOP_WORD;
        end else begin
            pc       <= next_pc;
            fd_instr <= jump_taken ? NOP_WORD : q_imem;  // Kill the slot behind a jump
        end
    end

    // PC travelling with the instruction
    always_ff @(posedge clock) begin
        fd_pc <= pc;
    end

endmodule

`default_nettype wire

//--- source/forwarding_unit.sv
/*
 * Forwarding unit
 * Matches execute source registers against memory and writeback destinations
 */
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit import cpu_pkg::*; (
    input  reg_addr_t dx_rs,
    input  reg_addr_t dx_rt,
    input  reg_addr_t xm_rd,
    input  logic      xm_reg_write,
    input  logic      xm_mem_read,
    input  reg_addr_t mw_rd,
    input  logic      mw_reg_write,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b
);

    // Youngest producer wins, so memory stage is checked first
    function automatic fwd_sel_t pick_source(
        input reg_addr_t src,
        input reg_addr_t xm_dst,
        input logic      xm_we,
        input logic      xm_load,
        input reg_addr_t mw_dst,
        input logic      mw_we
    );
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (xm_we && (xm_dst == src)) begin
            sel = xm_load ? FWD_LOAD : FWD_XM;  // Load data only exists on q_dmem
        end else if (mw_we && (mw_dst == src)) begin
            sel = FWD_MW;
        end
        return sel;
    endfunction

    // ----------------------------------------------------------
    // One selector per operand
    // ----------------------------------------------------------
    // $0 cannot match here, a zero destination never carries write enable
    always_comb begin
        fwd_a = pick_source(dx_rs, xm_rd, xm_reg_write, xm_mem_read, mw_rd, mw_reg_write);
        fwd_b = pick_source(dx_rt, xm_rd, xm_reg_write, xm_mem_read, mw_rd, mw_reg_write);
    end

endmodule

`default_nettype wire

//--- source/memory_writeback_stage.sv
/*
 * Memory and writeback stages
 * Drives data memory from XM, latches MW and drives the register file write port
 */
`timescale 1ns/1ps
`default_nettype none

module memory_writeback_stage import cpu_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  word_t     xm_result,
    input  word_t     xm_store_data,
    input  reg_addr_t xm_rd,
    input  logic      xm_reg_write,
    input  logic      xm_mem_read,
    input  logic      xm_mem_write,
    input  word_t     q_dmem,
    output word_t     address_dmem,
    output word_t     data,
    output logic      wren,
    output logic      ctrl_write_enable,
    output reg_addr_t ctrl_write_reg,
    output word_t     data_write_reg,
    output reg_addr_t mw_rd,
    output logic      mw_reg_write
);

    word_t mw_result;
    word_t mw_load_data;
    logic  mw_mem_read;

    // ----------------------------------------------------------
    // Memory access
    // ----------------------------------------------------------
    assign address_dmem = xm_result;
    assign data         = xm_store_data;  // Already forwarded in execute
    assign wren         = xm_mem_write;

    // MW latch
    always_ff @(posedge clock) begin
        if (reset) begin
            mw_reg_write <= 1'b0;
            mw_mem_read  <= 1'b0;
        end else begin
            mw_reg_write <= xm_reg_write;
            mw_mem_read  <= xm_mem_read;
        end
    end

    always_ff @(posedge clock) begin
        mw_result    <= xm_result;
        mw_load_data <= q_dmem;
        mw_rd        <= xm_rd;
    end

    // ----------------------------------------------------------
    // Writeback
    // ----------------------------------------------------------
    assign ctrl_write_enable = mw_reg_write;
    assign ctrl_write_reg    = mw_rd;
    assign data_write_reg    = mw_mem_read ? mw_load_data : mw_result;  // Load or ALU value

endmodule

`default_nettype wire

//--- source/processor.sv
/*
 * Five-stage pipelined core top level
 * Wires the stages together; memories and register file sit outside
 */
`timescale 1ns/1ps
`default_nettype none

module processor import cpu_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    // Instruction memory
    output word_t     address_imem,
    input  word_t     q_imem,
    // Data memory
    output word_t     address_dmem,
    output word_t     data,
    output logic      wren,
    input  word_t     q_dmem,
    // Register file
    output logic      ctrl_write_enable,
    output reg_addr_t ctrl_write_reg,
    output reg_addr_t ctrl_read_reg_a,
    output reg_addr_t ctrl_read_reg_b,
    output word_t     data_write_reg,
    input  word_t     data_read_reg_a,
    input  word_t     data_read_reg_b
);

    // Fetch to decode
    word_t      fd_instr;
    logic       jump_taken;
    word_t      jump_target;

    // Decode to execute
    word_t      dx_a, dx_b, dx_imm;
    reg_addr_t  dx_rs, dx_rt, dx_rd;
    logic [4:0] dx_shamt;
    alu_op_t    dx_alu_op;
    logic       dx_use_imm, dx_reg_write, dx_mem_read, dx_mem_write;

    // Execute to memory
    word_t      xm_result, xm_store_data;
    reg_addr_t  xm_rd;
    logic       xm_reg_write, xm_mem_read, xm_mem_write;

    // Writeback and forwarding
    reg_addr_t  mw_rd;
    logic       mw_reg_write;
    fwd_sel_t   fwd_a, fwd_b;

    fetch_stage fetch_i (
        .clock(clock), .reset(reset),
        .jump_taken(jump_taken), .jump_target(jump_target),
        .q_imem(q_imem), .address_imem(address_imem),
        .fd_instr(fd_instr),
        .fd_pc()  // Nothing in the core uses the instruction PC
    );

    decode_stage decode_i (
        .clock(clock), .reset(reset), .fd_instr(fd_instr),
        .data_read_reg_a(data_read_reg_a), .data_read_reg_b(data_read_reg_b),
        .ctrl_read_reg_a(ctrl_read_reg_a), .ctrl_read_reg_b(ctrl_read_reg_b),
        .jump_taken(jump_taken), .jump_target(jump_target),
        .dx_a(dx_a), .dx_b(dx_b), .dx_imm(dx_imm),
        .dx_rs(dx_rs), .dx_rt(dx_rt), .dx_rd(dx_rd),
        .dx_shamt(dx_shamt), .dx_alu_op(dx_alu_op), .dx_use_imm(dx_use_imm),
        .dx_reg_write(dx_reg_write), .dx_mem_read(dx_mem_read), .dx_mem_write(dx_mem_write)
    );

    forwarding_unit forwarding_i (
        .dx_rs(dx_rs), .dx_rt(dx_rt),
        .xm_rd(xm_rd), .xm_reg_write(xm_reg_write), .xm_mem_read(xm_mem_read),
        .mw_rd(mw_rd), .mw_reg_write(mw_reg_write),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    execute_stage execute_i (
        .clock(clock), .reset(reset),
        .dx_a(dx_a), .dx_b(dx_b), .dx_imm(dx_imm), .dx_rd(dx_rd),
        .dx_shamt(dx_shamt), .dx_alu_op(dx_alu_op), .dx_use_imm(dx_use_imm),
        .dx_reg_write(dx_reg_write), .dx_mem_read(dx_mem_read), .dx_mem_write(dx_mem_write),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .q_dmem(q_dmem), .data_write_reg(data_write_reg),
        .xm_result(xm_result), .xm_store_data(xm_store_data), .xm_rd(xm_rd),
        .xm_reg_write(xm_reg_write), .xm_mem_read(xm_mem_read), .xm_mem_write(xm_mem_write)
    );

    memory_writeback_stage memory_writeback_i (
        .clock(clock), .reset(reset),
        .xm_result(xm_result), .xm_store_data(xm_store_data), .xm_rd(xm_rd),
        .xm_reg_write(xm_reg_write), .xm_mem_read(xm_mem_read), .xm_mem_write(xm_mem_write),
        .q_dmem(q_dmem),
        .address_dmem(address_dmem), .data(data), .wren(wren),
        .ctrl_write_enable(ctrl_write_enable), .ctrl_write_reg(ctrl_write_reg),
        .data_write_reg(data_write_reg),
        .mw_rd(mw_rd), .mw_reg_write(mw_reg_write)
    );

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
/*
 * Testbench clock and reset
 * 40 ns clock, reset high for the first two cycles and released on a falling edge
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 2;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);  // Release away from the sampling edge
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/processor_tb.sv
/*
 * Testbench for the five-stage core
 * Random program, behavioral memories and register file, in-order reference model,
 * per-cycle checks of fetch order, register writes and stores
 */
`timescale 1ns/1ps
`default_nettype none

module processor_tb import cpu_pkg::*; ();

    localparam int PROG_LEN     = 200;
    localparam int CLOCK_PERIOD = 40;
    localparam int DRAIN_CYCLES = 5;   // Self-jump fetch to last write, plus one
    localparam int MEM_WORDS    = 256;

    logic      clock;
    logic      reset;
    word_t     address_imem;
    word_t     q_imem;
    word_t     address_dmem;
    word_t     data;
    word_t     q_dmem;
    logic      wren;
    logic      ctrl_write_enable;
    reg_addr_t ctrl_write_reg;
    reg_addr_t ctrl_read_reg_a;
    reg_addr_t ctrl_read_reg_b;
    word_t     data_write_reg;
    word_t     data_read_reg_a;
    word_t     data_read_reg_b;

    integer seed;
    word_t  imem [0:MEM_WORDS-1];
    word_t  dmem [0:MEM_WORDS-1];
    word_t  rf_mem [0:31];
    word_t  model_dmem [0:MEM_WORDS-1];
    word_t  model_rf [0:31];

    // Expected streams, in program order
    reg_addr_t exp_write_reg [$];
    word_t     exp_write_data [$];
    word_t     exp_store_addr [$];
    word_t     exp_store_data [$];

    // Fetch tracker
    word_t prev_addr;
    logic  prev_valid;
    word_t next_addr;
    int    drain_end;
    logic  done;

    clock_gen clock_gen_i (.clock(clock), .reset(reset));

    processor processor_i (
        .clock(clock), .reset(reset),
        .address_imem(address_imem), .q_imem(q_imem),
        .address_dmem(address_dmem), .data(data), .wren(wren), .q_dmem(q_dmem),
        .ctrl_write_enable(ctrl_write_enable), .ctrl_write_reg(ctrl_write_reg),
        .ctrl_read_reg_a(ctrl_read_reg_a), .ctrl_read_reg_b(ctrl_read_reg_b),
        .data_write_reg(data_write_reg),
        .data_read_reg_a(data_read_reg_a), .data_read_reg_b(data_read_reg_b)
    );

    // ----------------------------------------------------------
    // Behavioral memories and register file
    // ----------------------------------------------------------
    assign q_imem = $isunknown(address_imem) ? NOP_WORD : imem[address_imem[7:0]];
    assign q_dmem = $isunknown(address_dmem) ? '0 : dmem[address_dmem[7:0]];

    // Write-through reads, $0 pinned to zero
    assign data_read_reg_a =
        ($isunknown(ctrl_read_reg_a) || ctrl_read_reg_a == 5'd0) ? '0 :
        (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a) ? data_write_reg :
        rf_mem[ctrl_read_reg_a];
    assign data_read_reg_b =
        ($isunknown(ctrl_read_reg_b) || ctrl_read_reg_b == 5'd0) ? '0 :
        (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b) ? data_write_reg :
        rf_mem[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (wren === 1'b1)
            dmem[address_dmem[7:0]] <= data;
        if (ctrl_write_enable === 1'b1 && ctrl_write_reg != 5'd0)
            rf_mem[ctrl_write_reg] <= data_write_reg;
    end

    // ----------------------------------------------------------
    // Reporting
    // ----------------------------------------------------------
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        abort_run();
    endtask

    task automatic compare_value(input string test_name, input word_t expected,
                                 input word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
            abort_run();
        end
    endtask

    // ----------------------------------------------------------
    // Program generation
    // ----------------------------------------------------------
    function automatic int urand(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t fill_word(input int addr);
        return (addr * 32'h9e37_79b9) ^ (addr << 24) ^ 32'h5a5a_0f0f;  // Every address bit counts
    endfunction

    function automatic word_t encode_r(input logic [4:0] fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] sh);
        return {OP_RTYPE, rd, rs, rt, sh, fn, 2'b00};
    endfunction

    function automatic word_t encode_i(input logic [4:0] op, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic word_t encode_j(input int target);
        return {OP_J, 27'(target)};
    endfunction

    task automatic load_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i]       = NOP_WORD;  // Past the program only squashed slots read here
            dmem[i]       = fill_word(i);
            model_dmem[i] = fill_word(i);
        end
        for (int r = 0; r < 32; r++) begin
            rf_mem[r] = (r > 0 && r < 8) ? word_t'($random(seed)) : '0;
            model_rf[r] = rf_mem[r];
        end
    endtask

    task automatic build_program();
        int          kind;
        int          target;
        word_t       prev_word;
        logic [4:0]  store_rd;
        logic [16:0] load_imm;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind      = urand(10);
            prev_word = (i > 0) ? imem[i-1] : NOP_WORD;
            if (i == PROG_LEN - 1) begin
                imem[i] = encode_j(i);  // Final self-jump
            end else if (kind == 8 && i >= 4) begin
                target = i + 2 + urand(3);
                if (target > PROG_LEN - 1)
                    target = PROG_LEN - 1;
                imem[i] = encode_j(target);
            end else if (kind < 4 || kind == 8) begin
                imem[i] = encode_r(5'(urand(6)), 5'(urand(8)), 5'(urand(8)),
                                   5'(urand(8)), 5'(urand(32)));
            end else if (kind < 6) begin
                imem[i] = encode_i(OP_ADDI, 5'(urand(8)), 5'(urand(8)), 17'(urand(131072)));
            end else if (kind == 7) begin
                // Half the stores take their data from the instruction just before
                store_rd = urand(2) ? prev_word[26:22] : 5'(urand(8));
                imem[i]  = encode_i(OP_SW, store_rd, 5'd0, 17'(urand(256)));
            end else begin
                load_imm = 17'(urand(256));
                if (prev_word[31:27] == OP_SW && urand(2) == 1)
                    load_imm = prev_word[16:0];  // Read back what the store just wrote
                imem[i] = encode_i(OP_LW, 5'(urand(8)), 5'd0, load_imm);
            end
        end
    endtask

    // ----------------------------------------------------------
    // Reference model, in order, no pipeline
    // ----------------------------------------------------------
    task automatic record_write(input logic [4:0] rd, input word_t value);
        if (rd != 5'd0) begin  // $0 swallows writes
            model_rf[rd] = value;
            exp_write_reg.push_back(rd);
            exp_write_data.push_back(value);
        end
    endtask

    task automatic run_model();
        int    pc;
        int    steps;
        logic  halted;
        word_t instr;
        word_t a;
        word_t b;
        word_t imm;
        word_t addr;
        pc     = 0;
        steps  = 0;
        halted = 1'b0;
        while (!halted) begin
            instr = imem[pc];
            a     = model_rf[instr[21:17]];
            b     = model_rf[instr[16:12]];
            imm   = {{15{instr[16]}}, instr[16:0]};
            addr  = a + imm;
            case (instr[31:27])
                OP_RTYPE: begin
                    case (instr[6:2])
                        5'd0: record_write(instr[26:22], a + b);
                        5'd1: record_write(instr[26:22], a - b);
                        5'd2: record_write(instr[26:22], a & b);
                        5'd3: record_write(instr[26:22], a | b);
                        5'd4: record_write(instr[26:22], a << instr[11:7]);
                        default: record_write(instr[26:22], $signed(a) >>> instr[11:7]);
                    endcase
                end
                OP_ADDI: record_write(instr[26:22], addr);
                OP_LW:   record_write(instr[26:22], model_dmem[addr[7:0]]);
                OP_SW: begin
                    model_dmem[addr[7:0]] = model_rf[instr[26:22]];  // Data register sits in rd
                    exp_store_addr.push_back(addr);
                    exp_store_data.push_back(model_rf[instr[26:22]]);
                end
                default: ;
            endcase
            if (instr[31:27] == OP_J) begin
                halted = (int'(instr[26:0]) == pc);
                pc     = int'(instr[26:0]);
            end else begin
                pc = pc + 1;
            end
            steps++;
            if (steps > PROG_LEN)
                report_error("reference model ran past the program");
        end
    endtask

    // ----------------------------------------------------------
    // Per-cycle checks, sampled mid-cycle
    // ----------------------------------------------------------
    task automatic check_cycle(input int cycle);
        word_t prev_instr;
        logic  jump_in_decode;
        if (cycle == 0)
            compare_value("fetch_start", '0, address_imem);
        else
            compare_value("fetch_order", next_addr, address_imem);
        if (cycle < 3)
            compare_value("fill_wren", '0, wren);  // First sw reaches memory in cycle 3
        if (cycle < 4)
            compare_value("fill_write_enable", '0, ctrl_write_enable);
        if ($isunknown({wren, ctrl_write_enable}))
            report_error("write strobe is unknown");

        if (ctrl_write_enable) begin
            if (ctrl_write_reg == 5'd0)
                report_error("register write targets $0");
            else if (exp_write_reg.size() == 0)
                report_error("register write with no write left in the program");
            else begin
                compare_value("write_reg", exp_write_reg.pop_front(), ctrl_write_reg);
                compare_value("write_data", exp_write_data.pop_front(), data_write_reg);
            end
        end
        if (wren) begin
            if (exp_store_addr.size() == 0)
                report_error("store with no store left in the program");
            else begin
                compare_value("store_addr", exp_store_addr.pop_front(), address_dmem);
                compare_value("store_data", exp_store_data.pop_front(), data);
            end
        end

        // A valid j fetched last cycle is in decode now
        prev_instr     = imem[prev_addr[7:0]];
        jump_in_decode = (cycle > 0) && prev_valid && (prev_instr[31:27] == OP_J);
        next_addr      = jump_in_decode ? {5'd0, prev_instr[26:0]} : address_imem + 1;
        prev_valid     = !jump_in_decode;  // Slot behind a jump is squashed
        prev_addr      = address_imem;

        if (prev_valid && address_imem == PROG_LEN - 1 && drain_end < 0)
            drain_end = cycle + DRAIN_CYCLES;
        if (cycle == drain_end) begin
            if (exp_write_reg.size() != 0)
                report_error("program ended with register writes still missing");
            else if (exp_store_addr.size() != 0)
                report_error("program ended with stores still missing");
            else
                done = 1'b1;
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------
    initial begin : main
        int cycle;
        seed       = 32'h8b85958c;
        prev_addr  = '0;
        prev_valid = 1'b0;
        next_addr  = '0;
        drain_end  = -1;
        done       = 1'b0;
        load_memories();
        build_program();
        run_model();

        @(negedge clock);  // Inside reset, latches already cleared
        compare_value("reset_wren", '0, wren);
        compare_value("reset_write_enable", '0, ctrl_write_enable);

        @(negedge reset);
        cycle = 0;
        while (!done) begin
            check_cycle(cycle);
            if (!done) begin
                @(negedge clock);
                cycle++;
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin : watchdog
        #((PROG_LEN + 20) * CLOCK_PERIOD);
        $display("ERROR: timeout, the program never reached its final jump");
        abort_run();
    end

endmodule

`default_nettype wire
